/* src/cache_pkg.sv */
package cache_pkg;

    // Cache geometry
    localparam int NUM_WAYS       = 2;
    localparam int NUM_SETS       = 8;
    localparam int WORDS_PER_LINE = 8;

    localparam int DATA_BITS   = 32;                           // CPU word width
    localparam int OFFSET_BITS = 2;                            // Byte offset within a word
    localparam int WAY_BITS    = $clog2(NUM_WAYS);
    localparam int INDEX_BITS  = $clog2(NUM_SETS);
    localparam int WORD_BITS   = $clog2(WORDS_PER_LINE);
    localparam int TAG_BITS    = 32 - INDEX_BITS - WORD_BITS - OFFSET_BITS;

    // Byte address as the cache sees it
    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [INDEX_BITS-1:0]  index;
        logic [WORD_BITS-1:0]   word;                          // Word within the line
        logic [OFFSET_BITS-1:0] byte_off;                      // Always zero on the memory side
    } cache_addr_t;

    // One line as moved to and from physical memory
    typedef logic [WORDS_PER_LINE-1:0][DATA_BITS-1:0] cache_line_t;

    // Strobes from the controller to the datapath
    typedef struct packed {
        logic load_word;                                       // Store the CPU word in the hit way
        logic load_line;                                       // Fill the victim way from memory
        logic load_lru;                                        // Mark the hit way as recently used
        logic address_sel;                                     // 0 selects CPU line, 1 the victim line
    } cache_ctrl_t;

    // Status from the datapath back to the controller
    typedef struct packed {
        logic hit;                                             // Address matches a valid way
        logic dirty;                                           // Victim way is valid and dirty
    } cache_status_t;

endpackage

/* src/cache_control.sv */
`timescale 1ns/1ps

module cache_control import cache_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          mem_read,
    input  logic          mem_write,
    input  logic          pmem_resp,
    input  cache_status_t status,
    output cache_ctrl_t   ctrl,
    output logic          mem_resp,
    output logic          pmem_read,
    output logic          pmem_write
);

    typedef enum logic [1:0] {
        IDLE,                                                  // Compare tags and answer hits
        WRITE_BACK,                                            // Victim line goes out to memory
        FILL,                                                  // Missing line comes in from memory
        SETTLE                                                 // Let the new line show up as a hit
    } state_t;

    state_t state;
    state_t next_state;
    logic   request;

    assign request = mem_read || mem_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Strobes per state
    always_comb begin
        ctrl       = '0;
        mem_resp   = 1'b0;
        pmem_read  = 1'b0;
        pmem_write = 1'b0;

        unique case (state)
            IDLE: begin
                if (request && status.hit) begin
                    mem_resp      = 1'b1;                      // Hits are answered in the same cycle
                    ctrl.load_lru = 1'b1;
                    if (mem_write) begin
                        ctrl.load_word = 1'b1;                 // Word lands and the way turns dirty
                    end
                end
            end

            WRITE_BACK: begin
                ctrl.address_sel = 1'b1;                       // Memory sees the victim's own address
                pmem_write       = 1'b1;
            end

            FILL: begin
                // The victim is rewritten every cycle here, the pmem_resp edge leaves the real line
                pmem_read      = 1'b1;
                ctrl.load_line = 1'b1;
            end

            SETTLE: begin
                // No strobes while the filled line propagates to the tag compare
            end

            default: begin
            end
        endcase
    end

    // Next state
    always_comb begin
        next_state = state;

        unique case (state)
            IDLE: begin
                if (request && !status.hit) begin
                    if (status.dirty) begin
                        next_state = WRITE_BACK;               // Save the victim before replacing it
                    end else begin
                        next_state = FILL;
                    end
                end
            end

            WRITE_BACK: begin
                if (pmem_resp) begin
                    next_state = FILL;
                end
            end

            FILL: begin
                if (pmem_resp) begin
                    next_state = SETTLE;
                end
            end

            SETTLE: begin
                if (!pmem_resp) begin
                    next_state = IDLE;                         // Request is retried as a hit
                end
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

/* src/cache_datapath.sv */
`timescale 1ns/1ps

module cache_datapath import cache_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  cache_ctrl_t          ctrl,
    input  cache_addr_t          mem_address,
    input  logic [DATA_BITS-1:0] mem_wdata,
    input  cache_line_t          pmem_rdata,
    output cache_status_t        status,
    output logic [DATA_BITS-1:0] mem_rdata,
    output cache_addr_t          pmem_address,
    output cache_line_t          pmem_wdata
);

    // Storage arrays
    logic [TAG_BITS-1:0] tags  [NUM_SETS][NUM_WAYS];
    cache_line_t         data  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty [NUM_SETS];
    logic [WAY_BITS-1:0] lru   [NUM_SETS];                     // Number of the least recently used way

    logic [INDEX_BITS-1:0] idx;
    logic [NUM_WAYS-1:0]   hit_vec;
    logic [WAY_BITS-1:0]   hit_way;
    logic [WAY_BITS-1:0]   victim;

    assign idx    = mem_address.index;
    assign victim = lru[idx];                                  // Way 0 after reset

    // Tag compare across the ways of the selected set
    always_comb begin
        hit_vec = '0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = valid[idx][w] && (tags[idx][w] == mem_address.tag);
            if (hit_vec[w]) begin
                hit_way = WAY_BITS'(w);
            end
        end
    end

    assign status.hit   = |hit_vec;
    assign status.dirty = valid[idx][victim] && dirty[idx][victim];

    // Read word comes from the hit way, only meaningful on a hit
    assign mem_rdata = data[idx][hit_way][mem_address.word];

    // Line aligned memory address, from the CPU or from the victim's stored tag
    always_comb begin
        pmem_address       = '0;
        pmem_address.index = idx;
        if (ctrl.address_sel) begin
            pmem_address.tag = tags[idx][victim];
        end else begin
            pmem_address.tag = mem_address.tag;
        end
    end

    assign pmem_wdata = data[idx][victim];                     // Victim line for write-back

    // Tag and data storage
    always_ff @(posedge clk) begin
        if (ctrl.load_line) begin
            data[idx][victim] <= pmem_rdata;
            tags[idx][victim] <= mem_address.tag;
        end else if (ctrl.load_word) begin
            data[idx][hit_way][mem_address.word] <= mem_wdata;
        end
    end

    // Valid, dirty and LRU state
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
                lru[s]   <= '0;
            end
        end else begin
            if (ctrl.load_line) begin
                valid[idx][victim] <= 1'b1;                    // Freshly filled line is clean
                dirty[idx][victim] <= 1'b0;
            end else if (ctrl.load_word) begin
                dirty[idx][hit_way] <= 1'b1;
            end

            if (ctrl.load_lru) begin
                lru[idx] <= ~hit_way;                          // The other way becomes the victim
            end
        end
    end

endmodule

/* src/cache_top.sv */
`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    // CPU side
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  cache_addr_t          mem_address,
    input  logic [DATA_BITS-1:0] mem_wdata,
    output logic [DATA_BITS-1:0] mem_rdata,
    output logic                 mem_resp,

    // Physical memory side
    input  cache_line_t          pmem_rdata,
    input  logic                 pmem_resp,
    output logic                 pmem_read,
    output logic                 pmem_write,
    output cache_addr_t          pmem_address,
    output cache_line_t          pmem_wdata
);

    cache_ctrl_t   ctrl;
    cache_status_t status;

    cache_control control (
        .clk        (clk),
        .rst        (rst),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .pmem_resp  (pmem_resp),
        .status     (status),
        .ctrl       (ctrl),
        .mem_resp   (mem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write)
    );

    cache_datapath datapath (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .pmem_rdata   (pmem_rdata),
        .status       (status),
        .mem_rdata    (mem_rdata),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata)
    );

endmodule

/* bench/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                                 // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);                            // Ten rising edges in reset
        @(negedge clk);
        rst = 1'b0;                                            // Released on a falling edge
    end

endmodule

/* bench/cache_props.sv */
`timescale 1ns/1ps

module cache_props import cache_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        mem_read,
    input logic        mem_write,
    input logic        mem_resp,
    input logic        pmem_read,
    input logic        pmem_write,
    input cache_addr_t pmem_address,
    input cache_line_t pmem_wdata
);

    strobes_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(pmem_read && pmem_write)
    ) else $error("pmem_read and pmem_write are high in the same cycle");

    resp_needs_request: assert property (
        @(posedge clk) disable iff (rst) mem_resp |-> (mem_read || mem_write)
    ) else $error("mem_resp is high without a CPU request");

    // A held read keeps its line address until the response
    read_addr_stable: assert property (
        @(posedge clk) disable iff (rst)
            (pmem_read && $past(pmem_read)) |-> $stable(pmem_address)
    ) else $error("pmem_address changed while pmem_read was held");

    write_stable: assert property (
        @(posedge clk) disable iff (rst)
            (pmem_write && $past(pmem_write)) |-> ($stable(pmem_address) && $stable(pmem_wdata))
    ) else $error("pmem_address or pmem_wdata changed while pmem_write was held");

    quiet_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> !(pmem_read || pmem_write || mem_resp)
    ) else $error("A strobe is high in the first cycle after reset");

endmodule

bind cache_top cache_props props (
    .clk          (clk),
    .rst          (rst),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .mem_resp     (mem_resp),
    .pmem_read    (pmem_read),
    .pmem_write   (pmem_write),
    .pmem_address (pmem_address),
    .pmem_wdata   (pmem_wdata)
);

/* bench/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

    localparam int          MEM_WORDS  = 1024;                 // 4 KB physical window
    localparam int          TIMEOUT    = 200;
    localparam int          RANDOM_OPS = 2000;
    localparam logic [31:0] SEED       = 32'h36ff_ec27;

    logic                 clk;
    logic                 rst;
    logic                 mem_read;
    logic                 mem_write;
    cache_addr_t          mem_address;
    logic [DATA_BITS-1:0] mem_wdata;
    logic [DATA_BITS-1:0] mem_rdata;
    logic                 mem_resp;
    cache_line_t          pmem_rdata;
    logic                 pmem_resp;
    logic                 pmem_read;
    logic                 pmem_write;
    cache_addr_t          pmem_address;
    cache_line_t          pmem_wdata;

    logic [31:0] phys_mem [MEM_WORDS];
    logic [31:0] ref_mem  [MEM_WORDS];                         // What every word should read
    logic [31:0] stim_state;
    logic [31:0] lat_state;
    int          reads_seen;
    int          writes_seen;
    cache_addr_t last_read_addr;
    cache_addr_t last_write_addr;

    clock_gen clocks (
        .clk (clk),
        .rst (rst)
    );

    cache_top uut (
        .clk          (clk),
        .rst          (rst),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic cache_addr_t make_addr(input int tag, input int set_idx, input int word);
        cache_addr_t a;
        a = '0;
        a.tag   = TAG_BITS'(tag);
        a.index = INDEX_BITS'(set_idx);
        a.word  = WORD_BITS'(word);
        return a;
    endfunction

    // Line address has word and byte offset cleared
    function automatic cache_addr_t line_base(input cache_addr_t a);
        return cache_addr_t'({a[31:5], 5'b0});
    endfunction

    function automatic cache_line_t ref_line(input cache_addr_t a);
        cache_line_t l;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            l[i] = ref_mem[{a[11:5], 3'(i)}];
        end
        return l;
    endfunction

    task automatic report_failure(input string what);
        $display("Error at %0t: %s", $time, what);
        $display("Test failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "Stopping at the first error");
        end
    endtask

    task automatic check_word(input string name, input logic [DATA_BITS-1:0] got,
                              input logic [DATA_BITS-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "Stopping at the first error");
        end
    endtask

    task automatic check_line(input string name, input cache_line_t got, input cache_line_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "Stopping at the first error");
        end
    endtask

    task automatic check_addr(input string name, input cache_addr_t got, input cache_addr_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "Stopping at the first error");
        end
    endtask

    task automatic check_quiet();
        check_flag("mem_resp", mem_resp, 1'b0);
        check_flag("pmem_read", pmem_read, 1'b0);
        check_flag("pmem_write", pmem_write, 1'b0);
    endtask

    // Line traffic seen by the memory model since a step began
    task automatic expect_traffic(input string step, input int reads_before,
                                  input int writes_before, input int new_reads,
                                  input int new_writes);
        int reads;
        int writes;
        reads  = reads_seen - reads_before;
        writes = writes_seen - writes_before;
        if (reads != new_reads || writes != new_writes) begin
            report_failure($sformatf("%s expected %0d line reads and %0d write-backs, saw %0d and %0d",
                                     step, new_reads, new_writes, reads, writes));
        end
    endtask

    // One CPU request held until mem_resp is seen at a rising edge
    task automatic cpu_access(input logic is_write, input cache_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        @(negedge clk);
        mem_read    = !is_write;
        mem_write   = is_write;
        mem_address = addr;
        mem_wdata   = wdata;
        cycles      = 0;
        #1;
        while (!mem_resp) begin
            if (cycles == TIMEOUT) begin
                report_failure("No mem_resp within 200 cycles of a CPU request");
            end
            @(negedge clk);
            #1;
            cycles++;
        end
        rdata = mem_rdata;
        @(posedge clk);                                        // Request is taken at this edge
        @(negedge clk);
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    task automatic read_and_check(input cache_addr_t addr);
        logic [31:0] got;
        cpu_access(1'b0, addr, '0, got);
        check_word("mem_rdata", got, ref_mem[addr[11:2]]);
    endtask

    task automatic write_word(input cache_addr_t addr, input logic [31:0] data);
        logic [31:0] ignored;
        cpu_access(1'b1, addr, data, ignored);
        ref_mem[addr[11:2]] = data;
    endtask

    // Physical memory answers each strobe after 2 to 6 cycles
    initial begin : memory_model
        int lat;
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        lat_state  = SEED ^ 32'h5a5a_5a5a;
        forever begin
            @(negedge clk);
            if (pmem_read || pmem_write) begin
                if (pmem_address[31:12] != '0) begin
                    report_failure("Physical memory request outside the 4 KB window");
                end
                lat_state = xorshift32(lat_state);
                lat = 2 + int'(lat_state % 32'd5);
                repeat (lat - 1) @(negedge clk);
                if (pmem_write) begin
                    writes_seen++;
                    last_write_addr = pmem_address;
                    check_line("pmem_wdata", pmem_wdata, ref_line(pmem_address));
                    for (int i = 0; i < WORDS_PER_LINE; i++) begin
                        phys_mem[{pmem_address[11:5], 3'(i)}] = pmem_wdata[i];
                    end
                end else begin
                    reads_seen++;
                    last_read_addr = pmem_address;
                    for (int i = 0; i < WORDS_PER_LINE; i++) begin
                        pmem_rdata[i] = phys_mem[{pmem_address[11:5], 3'(i)}];
                    end
                end
                pmem_resp = 1'b1;
                @(negedge clk);
                pmem_resp = 1'b0;
            end
        end
    end

    initial begin : stimulus
        int          cycles;
        int          r0;
        int          w0;
        cache_addr_t a;
        cache_addr_t b;
        cache_addr_t c;
        logic [31:0] data;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_address = '0;
        mem_wdata   = '0;
        reads_seen  = 0;
        writes_seen = 0;
        stim_state  = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            stim_state  = xorshift32(stim_state);
            phys_mem[i] = stim_state;
            ref_mem[i]  = stim_state;
        end

        // Strobes stay low through reset and the cycle after
        cycles = 0;
        do begin
            @(negedge clk);
            #1;
            check_quiet();
            cycles++;
            if (cycles > 20) begin
                report_failure("Reset was never released");
            end
        end while (rst);
        @(negedge clk);
        #1;
        check_quiet();

        // Cold read miss fetches the aligned line
        a  = make_addr(8, 2, 3);
        r0 = reads_seen;
        w0 = writes_seen;
        read_and_check(a);
        expect_traffic("Cold read miss", r0, w0, 1, 0);
        check_addr("pmem_address", last_read_addr, line_base(a));

        // Write hit and read-back stay inside the cache
        b  = make_addr(8, 2, 5);
        r0 = reads_seen;
        w0 = writes_seen;
        stim_state = xorshift32(stim_state);
        data = stim_state;
        write_word(b, data);
        read_and_check(b);
        expect_traffic("Write hit and read-back", r0, w0, 0, 0);

        // Third dirty line in set 5 pushes out the first
        a = make_addr(9, 5, 1);
        b = make_addr(10, 5, 1);
        c = make_addr(11, 5, 1);
        stim_state = xorshift32(stim_state);
        write_word(a, stim_state);
        stim_state = xorshift32(stim_state);
        write_word(b, stim_state);
        r0 = reads_seen;
        w0 = writes_seen;
        stim_state = xorshift32(stim_state);
        write_word(c, stim_state);
        expect_traffic("Dirty eviction", r0, w0, 1, 1);
        check_addr("pmem_address", last_write_addr, line_base(a));

        // A, B, A, C leaves B as the evicted line
        a = make_addr(12, 6, 0);
        b = make_addr(13, 6, 2);
        c = make_addr(14, 6, 4);
        read_and_check(a);
        read_and_check(b);
        read_and_check(a);
        read_and_check(c);
        r0 = reads_seen;
        w0 = writes_seen;
        read_and_check(a);
        expect_traffic("LRU read of A", r0, w0, 0, 0);
        read_and_check(b);
        expect_traffic("LRU read of B", r0, w0, 1, 0);

        // Random reads and writes over the low 1 KB
        for (int n = 0; n < RANDOM_OPS; n++) begin
            stim_state = xorshift32(stim_state);
            a = cache_addr_t'(stim_state & 32'h0000_03fc);
            stim_state = xorshift32(stim_state);
            if (stim_state[0]) begin
                stim_state = xorshift32(stim_state);
                write_word(a, stim_state);
            end else begin
                read_and_check(a);
            end
        end

        $display("Test passed");
        $finish;
    end

endmodule

/* cache_top.f */
src/cache_pkg.sv
src/cache_control.sv
src/cache_datapath.sv
src/cache_top.sv
bench/clock_gen.sv
bench/cache_props.sv
bench/cache_tb.sv

/* run.sh */
#!/bin/sh
# Builds the cache testbench with Verilator and runs it
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module cache_tb \
    -f cache_top.f --Mdir obj_dir -o cache_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/cache_sim > sim.log 2>&1
grep -q "Test passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
